// ==== fetchPkg.sv ====
`default_nettype none

package fetchPkg;

    // halfword slots in one 64-bit fetch block.
    localparam int SLOTS = 4;

    // entries in the fetch queue between the PC stage and the splitter.
    localparam int QUEUE_DEPTH = 4;

    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH); // read and write pointer width.

    // one PC file entry per fetch ID.
    localparam int PCFILE_ENTRIES = 16;

    // PC as a halfword address. Bit 0 of the byte address is always zero and is not stored.
    typedef logic [30:0] Pc_t;

    typedef logic [3:0] FetchId_t; // wraps modulo 16.

    // raw instruction data of one fetch block.
    typedef logic [63:0] InstrBlock_t;

    typedef logic [SLOTS-1:0] SlotMask_t; // one bit per halfword slot.

    // slot index inside a block, which is also bits [1:0] of a Pc_t.
    typedef logic [1:0] SlotPos_t;

endpackage

`default_nettype wire

// ==== fetchBlockIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface fetchBlockIf;

    logic valid;
    logic ready;
    fetchPkg::Pc_t pc; // start PC, unaligned after a taken branch.
    fetchPkg::FetchId_t fetchId;
    fetchPkg::InstrBlock_t instr;
    fetchPkg::SlotPos_t branchPos; // slot of the predicted branch.
    logic cutAtBranch; // slots past branchPos are not part of the block.

    modport producer (
        output valid, pc, fetchId, instr, branchPos, cutAtBranch,
        input ready
    );

    modport consumer (
        input valid, pc, fetchId, instr, branchPos, cutAtBranch,
        output ready
    );

endinterface

`default_nettype wire

// ==== ProgramCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

module ProgramCounter (
    input logic clk,
    input logic rst,

    input logic redirectValid,
    input logic [31:0] redirectPc,
    input fetchPkg::FetchId_t redirectFetchId,

    input fetchPkg::InstrBlock_t instr,
    input logic bpFound,
    input logic bpTaken,
    input logic bpIsJump,
    input logic [31:0] bpSrc,
    input logic [31:0] bpDst,
    input logic bpMultiple,

    output logic [31:0] fetchAddr,
    output logic fetchEn,

    output logic pcWriteEn,
    output fetchPkg::FetchId_t pcWriteId,
    output fetchPkg::Pc_t pcWriteData,

    fetchBlockIf.producer fetchIf
);

    fetchPkg::Pc_t pc;
    fetchPkg::FetchId_t fetchId;
    fetchPkg::Pc_t nextPc;
    logic branchRedirects; // taken branch or jump.

    assign branchRedirects = bpFound && (bpTaken || bpIsJump);

    // a block is only offered when no redirect is pending this cycle.
    assign fetchIf.valid = !redirectValid;
    assign fetchEn = fetchIf.valid && fetchIf.ready;

    assign fetchAddr = {pc, 1'b0};

    // the memory answers in the same cycle, so the block goes straight downstream.
    assign fetchIf.pc = pc;
    assign fetchIf.fetchId = fetchId;
    assign fetchIf.instr = instr;
    assign fetchIf.branchPos = bpSrc[2:1];
    assign fetchIf.cutAtBranch = bpFound && (bpTaken || bpIsJump || bpMultiple);

    // the PC file remembers where each fetch ID started.
    assign pcWriteEn = fetchEn;
    assign pcWriteId = fetchId;
    assign pcWriteData = pc;

    always_comb begin
        if (branchRedirects) begin
            nextPc = bpDst[31:1];
        end
        else if (bpFound && bpMultiple) begin
            // a second branch follows in this block, so resume right after the first one.
            nextPc = bpSrc[31:1] + 31'd1;
        end
        else begin
            nextPc = {pc[30:2] + 29'd1, 2'b00}; // next aligned block.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            fetchId <= '0;
        end
        else if (redirectValid) begin
            pc <= redirectPc[31:1];
            fetchId <= redirectFetchId + 4'd1; // the redirecting op keeps its own ID.
        end
        else if (fetchEn) begin
            pc <= nextPc;
            fetchId <= fetchId + 4'd1;
        end
    end

endmodule

`default_nettype wire

// ==== PCFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module PCFile (
    input logic clk,

    input logic writeEn,
    input fetchPkg::FetchId_t writeId,
    input fetchPkg::Pc_t writeData,

    input fetchPkg::FetchId_t readId0,
    output fetchPkg::Pc_t readData0,

    input fetchPkg::FetchId_t readId1,
    output fetchPkg::Pc_t readData1
);

    // start PC of every fetch block, indexed by its fetch ID.
    fetchPkg::Pc_t entries [fetchPkg::PCFILE_ENTRIES];

    always_ff @(posedge clk) begin
        if (writeEn) begin
            entries[writeId] <= writeData;
        end
    end

    // reads are combinational. An entry written on an edge is visible right after it.
    assign readData0 = entries[readId0];
    assign readData1 = entries[readId1];

endmodule

`default_nettype wire

// ==== FetchQueue.sv ====
`timescale 1ns/1ps
`default_nettype none

module FetchQueue (
    input logic clk,
    input logic rst,
    input logic flush,

    fetchBlockIf.consumer fetchIf,
    fetchBlockIf.producer queueIf
);

    fetchPkg::Pc_t pcMem [fetchPkg::QUEUE_DEPTH];
    fetchPkg::FetchId_t idMem [fetchPkg::QUEUE_DEPTH];
    fetchPkg::InstrBlock_t instrMem [fetchPkg::QUEUE_DEPTH];
    fetchPkg::SlotPos_t posMem [fetchPkg::QUEUE_DEPTH];
    logic cutMem [fetchPkg::QUEUE_DEPTH];

    logic [fetchPkg::QUEUE_PTR_W-1:0] wrPtr;
    logic [fetchPkg::QUEUE_PTR_W-1:0] rdPtr;
    logic [fetchPkg::QUEUE_PTR_W:0] count;
    logic push;
    logic pop;

    assign fetchIf.ready = count != (fetchPkg::QUEUE_PTR_W + 1)'(fetchPkg::QUEUE_DEPTH);
    assign push = fetchIf.valid && fetchIf.ready;

    assign queueIf.valid = count != '0;
    assign pop = queueIf.valid && queueIf.ready;

    // the head comes straight out of the storage registers.
    assign queueIf.pc = pcMem[rdPtr];
    assign queueIf.fetchId = idMem[rdPtr];
    assign queueIf.instr = instrMem[rdPtr];
    assign queueIf.branchPos = posMem[rdPtr];
    assign queueIf.cutAtBranch = cutMem[rdPtr];

    always_ff @(posedge clk) begin
        if (push) begin
            pcMem[wrPtr] <= fetchIf.pc;
            idMem[wrPtr] <= fetchIf.fetchId;
            instrMem[wrPtr] <= fetchIf.instr;
            posMem[wrPtr] <= fetchIf.branchPos;
            cutMem[wrPtr] <= fetchIf.cutAtBranch;
        end
    end

    // pointers wrap on their own since the depth is a power of two.
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end
            else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== InstrSplitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module InstrSplitter (
    input logic clk,
    input logic rst,
    input logic flush,

    fetchBlockIf.consumer queueIf,

    output logic outValid,
    input logic outReady,
    output logic [31:0] outPc,
    output fetchPkg::FetchId_t outFetchId,
    output fetchPkg::InstrBlock_t outInstr,
    output fetchPkg::SlotMask_t outMask
);

    fetchPkg::SlotMask_t mask;
    logic load;

    // the output register takes a block when it is empty or drains this cycle.
    assign queueIf.ready = !outValid || outReady;
    assign load = queueIf.valid && queueIf.ready;

    always_comb begin
        for (int i = 0; i < fetchPkg::SLOTS; i++) begin
            // slots before the start PC belong to an earlier path.
            mask[i] = (fetchPkg::SlotPos_t'(i) >= queueIf.pc[1:0]) &&
                (!queueIf.cutAtBranch || fetchPkg::SlotPos_t'(i) <= queueIf.branchPos);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            outValid <= 1'b0;
        end
        else if (load) begin
            outValid <= 1'b1;
        end
        else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            outPc <= {queueIf.pc[30:2], 3'b000}; // aligned down to the 8-byte block.
            outFetchId <= queueIf.fetchId;
            outInstr <= queueIf.instr;
            outMask <= mask;
        end
    end

endmodule

`default_nettype wire

// ==== FetchUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module FetchUnit (
    input logic clk,
    input logic rst,

    output logic [31:0] fetchAddr,
    output logic fetchEn,
    input fetchPkg::InstrBlock_t instr,
    input logic bpFound,
    input logic bpTaken,
    input logic bpIsJump,
    input logic [31:0] bpSrc,
    input logic [31:0] bpDst,
    input logic bpMultiple,

    input logic redirectValid,
    input logic [31:0] redirectPc,
    input fetchPkg::FetchId_t redirectFetchId,

    input fetchPkg::FetchId_t pcReadAddr0,
    output logic [31:0] pcReadData0,
    input fetchPkg::FetchId_t pcReadAddr1,
    output logic [31:0] pcReadData1,

    output logic outValid,
    input logic outReady,
    output logic [31:0] outPc,
    output fetchPkg::FetchId_t outFetchId,
    output fetchPkg::InstrBlock_t outInstr,
    output fetchPkg::SlotMask_t outMask
);

    fetchBlockIf fetchIf ();
    fetchBlockIf queueIf ();

    logic pcWriteEn;
    fetchPkg::FetchId_t pcWriteId;
    fetchPkg::Pc_t pcWriteData;
    fetchPkg::Pc_t pcHalf0;
    fetchPkg::Pc_t pcHalf1;

    ProgramCounter programCounter (
        .clk(clk),
        .rst(rst),
        .redirectValid(redirectValid),
        .redirectPc(redirectPc),
        .redirectFetchId(redirectFetchId),
        .instr(instr),
        .bpFound(bpFound),
        .bpTaken(bpTaken),
        .bpIsJump(bpIsJump),
        .bpSrc(bpSrc),
        .bpDst(bpDst),
        .bpMultiple(bpMultiple),
        .fetchAddr(fetchAddr),
        .fetchEn(fetchEn),
        .pcWriteEn(pcWriteEn),
        .pcWriteId(pcWriteId),
        .pcWriteData(pcWriteData),
        .fetchIf(fetchIf.producer)
    );

    PCFile pcFile (
        .clk(clk),
        .writeEn(pcWriteEn),
        .writeId(pcWriteId),
        .writeData(pcWriteData),
        .readId0(pcReadAddr0),
        .readData0(pcHalf0),
        .readId1(pcReadAddr1),
        .readData1(pcHalf1)
    );

    // back to byte addresses for the later stages.
    assign pcReadData0 = {pcHalf0, 1'b0};
    assign pcReadData1 = {pcHalf1, 1'b0};

    // a redirect flushes everything that is in flight.
    FetchQueue fetchQueue (
        .clk(clk),
        .rst(rst),
        .flush(redirectValid),
        .fetchIf(fetchIf.consumer),
        .queueIf(queueIf.producer)
    );

    InstrSplitter instrSplitter (
        .clk(clk),
        .rst(rst),
        .flush(redirectValid),
        .queueIf(queueIf.consumer),
        .outValid(outValid),
        .outReady(outReady),
        .outPc(outPc),
        .outFetchId(outFetchId),
        .outInstr(outInstr),
        .outMask(outMask)
    );

endmodule

`default_nettype wire

// ==== FetchUnit_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module FetchUnit_assertions (
    input logic clk,
    input logic rst,
    input logic fetchEn,
    input logic redirectValid,
    input logic outValid,
    input logic outReady,
    input logic [31:0] outPc,
    input fetchPkg::FetchId_t outFetchId,
    input fetchPkg::InstrBlock_t outInstr,
    input fetchPkg::SlotMask_t outMask
);

    // a stalled block holds until it is taken, unless a redirect flushes it.
    property holdWhileStalled;
        @(posedge clk) disable iff (rst)
        outValid && !outReady && !redirectValid |=>
            outValid && $stable(outPc) && $stable(outFetchId) &&
            $stable(outInstr) && $stable(outMask);
    endproperty

    assert property (holdWhileStalled)
        else $error("output block changed while stalled");

    assert property (@(posedge clk) rst |=> !outValid)
        else $error("outValid high right after reset");

    // the redirect cycle never fetches.
    assert property (@(posedge clk) disable iff (rst) redirectValid |-> !fetchEn)
        else $error("fetchEn high during a redirect");

endmodule

bind FetchUnit FetchUnit_assertions fetchUnitChecks (
    .clk(clk),
    .rst(rst),
    .fetchEn(fetchEn),
    .redirectValid(redirectValid),
    .outValid(outValid),
    .outReady(outReady),
    .outPc(outPc),
    .outFetchId(outFetchId),
    .outInstr(outInstr),
    .outMask(outMask)
);

`default_nettype wire

// ==== FetchUnit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module FetchUnit_tb;

    typedef struct packed {
        fetchPkg::Pc_t pc;
        fetchPkg::FetchId_t fetchId;
        fetchPkg::InstrBlock_t instr;
        fetchPkg::SlotMask_t mask;
    } OutBlock_t;

    localparam int TARGET_BLOCKS = 400;
    localparam int RUN_LIMIT = 6000;
    localparam int STALL_LIMIT = 100; // cycles without an accepted output block.

    logic clk;
    logic rst;
    logic [31:0] fetchAddr;
    logic fetchEn;
    fetchPkg::InstrBlock_t instr;
    logic bpFound;
    logic bpTaken;
    logic bpIsJump;
    logic [31:0] bpSrc;
    logic [31:0] bpDst;
    logic bpMultiple;
    logic redirectValid;
    logic [31:0] redirectPc;
    fetchPkg::FetchId_t redirectFetchId;
    fetchPkg::FetchId_t pcReadAddr0;
    logic [31:0] pcReadData0;
    fetchPkg::FetchId_t pcReadAddr1;
    logic [31:0] pcReadData1;
    logic outValid;
    logic outReady;
    logic [31:0] outPc;
    fetchPkg::FetchId_t outFetchId;
    fetchPkg::InstrBlock_t outInstr;
    fetchPkg::SlotMask_t outMask;

    integer seed;
    OutBlock_t expQ[$]; // issued blocks that have not left the output yet.
    logic [31:0] modelAddr;
    fetchPkg::FetchId_t modelId;
    logic [31:0] pcModel [fetchPkg::PCFILE_ENTRIES];
    logic pcKnown [fetchPkg::PCFILE_ENTRIES];

    FetchUnit FetchUnit_i (.*);

    always #2 clk = ~clk;

    // instruction memory contents, built from every bit of the fetch address.
    function automatic fetchPkg::InstrBlock_t memWord(input logic [31:0] addr);
        return {addr ^ 32'h5a5a_c3c3, {addr[15:0], addr[31:16]} ^ 32'h0f1e_2d3c};
    endfunction

    function automatic int pickBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic fetchPkg::SlotMask_t slotMask(input logic [31:0] startAddr,
                                                     input logic cut,
                                                     input logic [31:0] branchAddr);
        fetchPkg::SlotMask_t m;
        int first;
        int last;
        first = int'(startAddr[2:1]);
        last = cut ? int'(branchAddr[2:1]) : fetchPkg::SLOTS - 1;
        for (int i = 0; i < fetchPkg::SLOTS; i++) begin
            m[i] = (i >= first) && (i <= last);
        end
        return m;
    endfunction

    function automatic logic [31:0] nextAddr(input logic [31:0] addr);
        if (bpFound && (bpTaken || bpIsJump)) begin
            return bpDst;
        end
        if (bpFound && bpMultiple) begin
            return bpSrc + 32'd2; // resume right after the first branch.
        end
        return {addr[31:3] + 29'd1, 3'b000};
    endfunction

    task automatic mismatch(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "stopping at the first mismatch");
    endtask

    task automatic giveUp(input string msg);
        $display("%s (at %0t ns)", msg, $time);
        $display("Errors found");
        $fatal(1, "stopping after a timeout");
    endtask

    task automatic checkPc(input string what, input fetchPkg::Pc_t got,
                           input fetchPkg::Pc_t exp);
        if (got !== exp) begin
            mismatch($sformatf("%s is %h, expected %h", what, {got, 1'b0}, {exp, 1'b0}));
        end
    endtask

    task automatic checkFetchId(input fetchPkg::FetchId_t got, input fetchPkg::FetchId_t exp);
        if (got !== exp) begin
            mismatch($sformatf("outFetchId is %0d, expected %0d", got, exp));
        end
    endtask

    task automatic checkBlock(input fetchPkg::InstrBlock_t got, input fetchPkg::InstrBlock_t exp);
        if (got !== exp) begin
            mismatch($sformatf("outInstr is %h, expected %h", got, exp));
        end
    endtask

    task automatic checkMask(input fetchPkg::SlotMask_t got, input fetchPkg::SlotMask_t exp);
        if (got !== exp) begin
            mismatch($sformatf("outMask is %b, expected %b", got, exp));
        end
    endtask

    task automatic checkFlag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    // hints always describe a branch inside the current block, at or after the PC.
    task automatic driveCycle();
        int firstSlot;
        firstSlot = int'(fetchAddr[2:1]);
        instr = memWord(fetchAddr);
        bpFound = pickBelow(100) < 30;
        bpTaken = pickBelow(2) == 1;
        bpIsJump = pickBelow(100) < 20;
        bpMultiple = pickBelow(100) < 40;
        bpSrc = {fetchAddr[31:3], 3'b000} +
            32'(2 * (firstSlot + pickBelow(fetchPkg::SLOTS - firstSlot)));
        bpDst = 32'($random(seed)) & 32'hffff_fffe;
        redirectValid = pickBelow(100) < 4;
        redirectPc = 32'($random(seed)) & 32'hffff_fffe;
        redirectFetchId = 4'(pickBelow(16));
        pcReadAddr0 = 4'(pickBelow(16));
        pcReadAddr1 = 4'(pickBelow(16));
        outReady = pickBelow(100) < 70;
    endtask

    initial begin
        OutBlock_t blk;
        int queued;
        int transfers;
        int cycles;
        int idleCycles;
        logic expOutValid;
        logic headMoves;
        seed = 32'h82c;
        clk = 1'b0;
        rst = 1'b1;
        instr = '0;
        bpFound = 1'b0;
        bpTaken = 1'b0;
        bpIsJump = 1'b0;
        bpSrc = '0;
        bpDst = '0;
        bpMultiple = 1'b0;
        redirectValid = 1'b0;
        redirectPc = '0;
        redirectFetchId = '0;
        pcReadAddr0 = '0;
        pcReadAddr1 = '0;
        outReady = 1'b0;
        for (int i = 0; i < fetchPkg::PCFILE_ENTRIES; i++) begin
            pcKnown[i] = 1'b0;
        end
        modelAddr = '0;
        modelId = '0;
        expOutValid = 1'b0;
        transfers = 0;
        cycles = 0;
        idleCycles = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        while (transfers < TARGET_BLOCKS) begin
            if (cycles == RUN_LIMIT) begin
                giveUp("timeout: the run did not reach its block count in time");
            end
            driveCycle();
            #1; // everything below is what the next rising edge will see.

            if (pcKnown[pcReadAddr0]) begin
                checkPc("pcReadData0", pcReadData0[31:1], pcModel[pcReadAddr0][31:1]);
            end
            if (pcKnown[pcReadAddr1]) begin
                checkPc("pcReadData1", pcReadData1[31:1], pcModel[pcReadAddr1][31:1]);
            end

            checkFlag("outValid", outValid, expOutValid);

            // the block in the output register is not in the queue any more.
            queued = expQ.size() - int'(expOutValid);
            checkFlag("fetchEn", fetchEn,
                !redirectValid && (queued != fetchPkg::QUEUE_DEPTH));
            headMoves = (queued != 0) && (!expOutValid || outReady);

            if (expOutValid && outReady) begin
                blk = expQ.pop_front();
                checkPc("outPc", outPc[31:1], blk.pc);
                checkFetchId(outFetchId, blk.fetchId);
                checkBlock(outInstr, blk.instr);
                checkMask(outMask, blk.mask);
                transfers++;
                idleCycles = 0;
            end
            else begin
                idleCycles++;
            end
            if (idleCycles == STALL_LIMIT) begin
                giveUp("timeout: no output block was accepted for too long");
            end

            if (fetchEn) begin
                checkPc("fetchAddr", fetchAddr[31:1], modelAddr[31:1]);
                blk.pc = {modelAddr[31:3], 2'b00};
                blk.fetchId = modelId;
                blk.instr = memWord(modelAddr);
                blk.mask = slotMask(modelAddr,
                    bpFound && (bpTaken || bpIsJump || bpMultiple), bpSrc);
                expQ.push_back(blk);
                pcModel[modelId] = modelAddr;
                pcKnown[modelId] = 1'b1;
                modelAddr = nextAddr(modelAddr);
                modelId = modelId + 4'd1;
            end

            // the output holds a block if the queue head moved up or a stalled block stays.
            expOutValid = !redirectValid && (headMoves || (expOutValid && !outReady));
            if (redirectValid) begin
                expQ.delete(); // nothing fetched before the redirect may come out.
                modelAddr = redirectPc;
                modelId = redirectFetchId + 4'd1;
            end
            cycles++;
            @(negedge clk);
        end

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
fetchPkg.sv
fetchBlockIf.sv
ProgramCounter.sv
PCFile.sv
FetchQueue.sv
InstrSplitter.sv
FetchUnit.sv
FetchUnit_assertions.sv
FetchUnit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= FetchUnit_tb
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert -Wall
FAIL_MSG := Errors found
PASS_MSG := No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
